// ==== verilog/paletteFormatPkg.sv ====
//==========================================================================
// Palette format definitions
// Bit layout of the 16-bit palette word and the width of a colour channel
//==========================================================================
`default_nettype none

package paletteFormatPkg;

	// Palette word as the CPU writes it
	localparam int PALETTE_DATA_WIDTH = 16;

	// One output colour channel
	localparam int COLOR_WIDTH = 8;

	typedef logic [COLOR_WIDTH-1:0] colorT;

	// Colour view of a palette word
	// Dark lowers every channel by one step
	// The three lsb bits extend each 4-bit channel to 5 bits
	typedef struct packed {
		logic       dark;
		logic       redLsb;
		logic       greenLsb;
		logic       blueLsb;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} paletteFieldsT;

	// Same 16 bits seen as CPU data or as colour fields
	typedef union packed {
		logic [PALETTE_DATA_WIDTH-1:0] raw;
		paletteFieldsT                 fields;
	} paletteWordT;

endpackage

`default_nettype wire

// ==== verilog/videoTimingPkg.sv ====
//==========================================================================
// Video timing and system latch constants
// Pixel clock ratio and the select map of the bit-addressed latch
//==========================================================================
`default_nettype none

package videoTimingPkg;

	// 48 MHz master clock down to the 6 MHz pixel rate
	localparam int PIXEL_DIVIDE_DEFAULT = 8;

	// Latch address layout
	// Bits 3..1 pick one of eight latches
	// Bit 0 is the value stored in it
	localparam int LATCH_ADDR_WIDTH = 4;

	typedef logic [LATCH_ADDR_WIDTH-2:0] latchSelT;

	// Shadow halves all colour channels
	localparam latchSelT LATCH_SEL_SHADOW = 3'd0;

	// Palette bank picks the upper or lower 4096 words
	localparam latchSelT LATCH_SEL_PALBANK = 3'd7;

	// Selects 1 to 6 belong to latches that are not built here

endpackage

`default_nettype wire

// ==== verilog/cpuBusIf.sv ====
//==========================================================================
// CPU write bus
// Palette and system latch write strobes with their address and data
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

interface cpuBusIf #(
	parameter int IndexWidth = 12
);

	// Palette write, one clock wide
	logic palWrite;
	logic [IndexWidth-1:0] palAddr;
	paletteFormatPkg::paletteWordT palData;

	// System latch write, one clock wide
	logic latchWrite;
	logic [videoTimingPkg::LATCH_ADDR_WIDTH-1:0] latchAddr;

	// Top level side that drives everything
	modport host (
		output palWrite, palAddr, palData,
		output latchWrite, latchAddr
	);

	// Palette RAM write port
	modport palette (input palWrite, palAddr, palData);

	// Bit-addressed latch
	modport latch (input latchWrite, latchAddr);

endinterface

`default_nettype wire

// ==== verilog/systemLatch.sv ====
//==========================================================================
// System latch
// Bit-addressed register block holding the shadow flag and palette bank
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module systemLatch (
	input wire CLK_48M,
	input wire nRESET,

	cpuBusIf.latch bus,

	output logic shadow,
	output logic palBank
);

	// Address split
	videoTimingPkg::latchSelT latchSel;
	logic latchValue;

	// Upper address bits pick the latch
	assign latchSel = bus.latchAddr[videoTimingPkg::LATCH_ADDR_WIDTH-1:1];

	// Lowest address bit is the data
	assign latchValue = bus.latchAddr[0];

	//======================================================================
	// Latch update
	//======================================================================

	// New value shows on the cycle after the strobe
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow <= 1'b0;
			palBank <= 1'b0;
		end else if (bus.latchWrite) begin
			case (latchSel)
				videoTimingPkg::LATCH_SEL_SHADOW: begin
					shadow <= latchValue;
				end
				videoTimingPkg::LATCH_SEL_PALBANK: begin
					palBank <= latchValue;
				end
				default: begin
					// Vector, card and SRAM latches are not kept
					// so the write falls through
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/paletteRam.sv ====
//==========================================================================
// Palette RAM
// Two banks of palette words with a CPU write port and a video read port
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module paletteRam #(
	parameter int IndexWidth = 12
) (
	input wire CLK_48M,

	cpuBusIf.palette bus,

	input wire palBank,
	input wire [IndexWidth-1:0] readIndex,

	output paletteFormatPkg::paletteWordT readWord
);

	// Both banks in one array
	localparam int Depth = 2 ** (IndexWidth + 1);

	paletteFormatPkg::paletteWordT ram [Depth];

	logic [IndexWidth:0] writeAddr;
	logic [IndexWidth:0] readAddr;

	// Bank bit on top of the index for both ports
	assign writeAddr = {palBank, bus.palAddr};
	assign readAddr = {palBank, readIndex};

	//======================================================================
	// Memory ports
	//======================================================================

	// CPU write lands on the strobe edge
	// Registered read
	// A read of the word being written returns the old contents
	always_ff @(posedge CLK_48M) begin
		if (bus.palWrite) begin
			ram[writeAddr] <= bus.palData;
		end
		readWord <= ram[readAddr];
	end

endmodule

`default_nettype wire

// ==== verilog/pixelPipeline.sv ====
//==========================================================================
// Pixel pipeline
// Pixel enable, index sampling, palette word decode and colour registers
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module pixelPipeline #(
	parameter int IndexWidth = 12,
	parameter int PixelDivide = videoTimingPkg::PIXEL_DIVIDE_DEFAULT
) (
	input wire CLK_48M,
	input wire nRESET,

	input wire [IndexWidth-1:0] pixelIndex,
	input paletteFormatPkg::paletteWordT readWord,
	input wire shadow,

	output logic [IndexWidth-1:0] readIndex,
	output paletteFormatPkg::colorT red,
	output paletteFormatPkg::colorT green,
	output paletteFormatPkg::colorT blue,
	output logic ceOut
);

	// Divider sizing
	localparam int CountWidth = (PixelDivide > 2) ? $clog2(PixelDivide) : 1;
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(PixelDivide - 1);

	logic [CountWidth-1:0] divCount;

	// Colour view of the word coming back from the RAM
	paletteFormatPkg::paletteFieldsT fields;

	assign fields = readWord.fields;

	//======================================================================
	// Channel decode
	//======================================================================

	// 4 main bits, the lsb bit, then the main msb repeated
	// Dark subtracts one, clamped at zero
	// 6 bits widened to 8 by repeating bits 4 and 3
	// Shadow halves the result
	function automatic paletteFormatPkg::colorT decodeChannel(
		input logic [3:0] main,
		input logic lsb,
		input logic dark,
		input logic shade
	);
		logic [6:0] level;
		paletteFormatPkg::colorT full;

		level = {1'b0, main, lsb, main[3]} - {6'd0, dark};
		// Borrow out of bit 5 means the channel was already zero
		if (level[6]) begin
			full = '0;
		end else begin
			full = {level[5:0], level[4:3]};
		end
		if (shade) begin
			return {1'b0, full[7:1]};
		end
		return full;
	endfunction

	//======================================================================
	// Pixel enable
	//======================================================================

	// Counter wraps every PixelDivide cycles
	// Pulse is registered so the first one follows release by PixelDivide cycles
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			divCount <= '0;
			ceOut <= 1'b0;
		end else begin
			ceOut <= (divCount == LastCount);
			if (divCount == LastCount) begin
				divCount <= '0;
			end else begin
				divCount <= divCount + 1'b1;
			end
		end
	end

	//======================================================================
	// Index and colour registers
	//======================================================================

	// Index held for the whole pixel so the RAM read settles
	always_ff @(posedge CLK_48M) begin
		if (ceOut) begin
			readIndex <= pixelIndex;
		end
	end

	// Word read for the previous index is decoded on the next pixel
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (ceOut) begin
			red <= decodeChannel(fields.red, fields.redLsb, fields.dark, shadow);
			green <= decodeChannel(fields.green, fields.greenLsb, fields.dark, shadow);
			blue <= decodeChannel(fields.blue, fields.blueLsb, fields.dark, shadow);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/paletteTop.sv ====
//==========================================================================
// Palette and colour output top level
// CPU writes into palette RAM and latch, pixel index out to RGB
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module paletteTop #(
	parameter int IndexWidth = 12,
	parameter int PixelDivide = videoTimingPkg::PIXEL_DIVIDE_DEFAULT
) (
	input wire CLK_48M,
	input wire nRESET,

	// CPU palette write
	input wire palWrite,
	input wire [IndexWidth-1:0] palAddr,
	input wire [paletteFormatPkg::PALETTE_DATA_WIDTH-1:0] palData,

	// CPU latch write
	input wire latchWrite,
	input wire [videoTimingPkg::LATCH_ADDR_WIDTH-1:0] latchAddr,

	// Index from the line buffers
	input wire [IndexWidth-1:0] pixelIndex,

	// Video out
	output paletteFormatPkg::colorT red,
	output paletteFormatPkg::colorT green,
	output paletteFormatPkg::colorT blue,
	output logic ceOut
);

	// Latch outputs
	logic shadow;
	logic palBank;

	// Video read path
	logic [IndexWidth-1:0] readIndex;
	paletteFormatPkg::paletteWordT readWord;

	//======================================================================
	// CPU bus
	//======================================================================

	cpuBusIf #(.IndexWidth(IndexWidth)) cpuBus ();

	assign cpuBus.palWrite = palWrite;
	assign cpuBus.palAddr = palAddr;
	assign cpuBus.palData = paletteFormatPkg::paletteWordT'(palData);
	assign cpuBus.latchWrite = latchWrite;
	assign cpuBus.latchAddr = latchAddr;

	//======================================================================
	// Blocks
	//======================================================================

	systemLatch systemLatch_i (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.bus(cpuBus.latch),
		.shadow(shadow),
		.palBank(palBank)
	);

	paletteRam #(.IndexWidth(IndexWidth)) paletteRam_i (
		.CLK_48M(CLK_48M),
		.bus(cpuBus.palette),
		.palBank(palBank),
		.readIndex(readIndex),
		.readWord(readWord)
	);

	pixelPipeline #(
		.IndexWidth(IndexWidth),
		.PixelDivide(PixelDivide)
	) pixelPipeline_i (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.pixelIndex(pixelIndex),
		.readWord(readWord),
		.shadow(shadow),
		.readIndex(readIndex),
		.red(red),
		.green(green),
		.blue(blue),
		.ceOut(ceOut)
	);

endmodule

`default_nettype wire

// ==== sim/paletteTb.sv ====
//==========================================================================
// Palette path testbench
// Trace-driven lookup, dark, shadow and bank checks plus random words
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module paletteTb;

	localparam int IndexWidth = 12;
	localparam int Divide = videoTimingPkg::PIXEL_DIVIDE_DEFAULT;
	// Upper bound for any wait on the pixel enable
	localparam int WaitLimit = 64;

	logic CLK_48M;
	logic nRESET;
	logic palWrite;
	logic [IndexWidth-1:0] palAddr;
	logic [paletteFormatPkg::PALETTE_DATA_WIDTH-1:0] palData;
	logic latchWrite;
	logic [videoTimingPkg::LATCH_ADDR_WIDTH-1:0] latchAddr;
	logic [IndexWidth-1:0] pixelIndex;
	paletteFormatPkg::colorT red;
	paletteFormatPkg::colorT green;
	paletteFormatPkg::colorT blue;
	logic ceOut;

	int valueErrors;
	int timeoutErrors;
	int otherErrors;
	int seed;

	paletteTop #(
		.IndexWidth(IndexWidth),
		.PixelDivide(Divide)
	) dut_i (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.palWrite(palWrite),
		.palAddr(palAddr),
		.palData(palData),
		.latchWrite(latchWrite),
		.latchAddr(latchAddr),
		.pixelIndex(pixelIndex),
		.red(red),
		.green(green),
		.blue(blue),
		.ceOut(ceOut)
	);

	// 100 ns period
	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	//======================================================================
	// Reference colour model
	//======================================================================

	// Channel index 0 is red, 1 green and 2 blue
	// Level is main*4 + lsb*2 + main msb
	// Dark takes one off and the level stops at zero
	function automatic paletteFormatPkg::colorT refChannel(
		input logic [15:0] word,
		input int channel,
		input logic shade
	);
		int main;
		int lsb;
		int level;
		int full;

		main = int'((word >> (8 - 4 * channel)) & 16'hF);
		lsb = int'((word >> (14 - channel)) & 16'h1);
		level = main * 4 + lsb * 2 + main / 8;
		if (word[15]) begin
			level = level - 1;
		end
		if (level < 0) begin
			full = 0;
		end else begin
			// Level bits 4 and 3 fill the two low bits
			full = level * 4 + (level / 8) % 4;
		end
		if (shade) begin
			full = full / 2;
		end
		return paletteFormatPkg::colorT'(full);
	endfunction

	//======================================================================
	// Bus tasks
	//======================================================================

	// Inputs change 10 ns after the edge
	// Outputs are settled by then
	task automatic nextCycle();
		@(posedge CLK_48M);
		#10;
	endtask

	task automatic writePalette(input logic [IndexWidth-1:0] addr, input logic [15:0] data);
		palAddr = addr;
		palData = data;
		palWrite = 1'b1;
		nextCycle();
		palWrite = 1'b0;
	endtask

	// Address bits 3..1 select the latch and bit 0 is the value
	task automatic writeLatch(input logic [3:0] addr);
		latchAddr = addr;
		latchWrite = 1'b1;
		nextCycle();
		latchWrite = 1'b0;
	endtask

	// Steps until ceOut is high
	// The following edge is a pixel edge
	task automatic waitForCe(output int cycles);
		cycles = 0;
		do begin
			nextCycle();
			cycles++;
		end while (!ceOut && cycles < WaitLimit);
		assert (ceOut) else begin
			timeoutErrors++;
			$display("Timeout, no pixel enable pulse within %0d cycles", WaitLimit);
		end
	endtask

	task automatic checkColor(input string name, input logic [7:0] got, input logic [7:0] want);
		assert (got === want) else begin
			valueErrors++;
			$display("Error %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int want);
		assert (got == want) else begin
			valueErrors++;
			$display("Error %s got %h expected %h", name, got, want);
		end
	endtask

	// Index sampled on one pulse and colour registered on the next one
	task automatic checkPixel(
		input logic [IndexWidth-1:0] index,
		input logic [7:0] wantRed,
		input logic [7:0] wantGreen,
		input logic [7:0] wantBlue
	);
		int cycles;

		waitForCe(cycles);
		pixelIndex = index;
		waitForCe(cycles);
		nextCycle();
		checkColor("red", red, wantRed);
		checkColor("green", green, wantGreen);
		checkColor("blue", blue, wantBlue);
	endtask

	//======================================================================
	// Trace replay
	//======================================================================

	task automatic runTrace();
		int fd;
		int code;
		logic [7:0] op;
		logic [1023:0] rest;
		logic [15:0] addr;
		logic [15:0] data;
		logic [7:0] wantRed;
		logic [7:0] wantGreen;
		logic [7:0] wantBlue;

		fd = $fopen("sim/paletteTrace.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Cannot open the trace file sim/paletteTrace.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", op);
			if (code == 1) begin
				if (op == "#") begin
					// Rest of a comment line is skipped
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %h %h", addr, data, wantRed, wantGreen,
						wantBlue);
					if (code != 5) begin
						otherErrors++;
						$display("Malformed operation line in the trace file");
					end else begin
						case (op)
							"W": writePalette(addr[IndexWidth-1:0], data);
							"L": writeLatch(addr[3:0]);
							"P": checkPixel(addr[IndexWidth-1:0], wantRed, wantGreen,
								wantBlue);
							default: begin
								otherErrors++;
								$display("Unknown operation in the trace file");
							end
						endcase
					end
				end
			end
		end
		$fclose(fd);
	endtask

	//======================================================================
	// Main sequence
	//======================================================================

	initial begin
		int cycles;
		logic [15:0] word;
		logic [IndexWidth-1:0] index;
		logic shade;

		valueErrors = 0;
		timeoutErrors = 0;
		otherErrors = 0;
		seed = 32'h4145_ad28;
		nRESET = 1'b0;
		palWrite = 1'b0;
		palAddr = '0;
		palData = '0;
		latchWrite = 1'b0;
		latchAddr = '0;
		pixelIndex = '0;

		repeat (16) nextCycle();
		checkColor("red", red, 8'h00);
		checkColor("green", green, 8'h00);
		checkColor("blue", blue, 8'h00);
		nRESET = 1'b1;

		// First pulse and two full periods
		waitForCe(cycles);
		checkCount("ceOut first pulse", cycles, Divide);
		// Colour registers still hold their reset value up to the first pixel edge
		checkColor("red", red, 8'h00);
		checkColor("green", green, 8'h00);
		checkColor("blue", blue, 8'h00);
		repeat (2) begin
			waitForCe(cycles);
			checkCount("ceOut period", cycles, Divide);
		end

		runTrace();

		// Random words in bank 0 with shadow on for odd passes
		writeLatch({videoTimingPkg::LATCH_SEL_PALBANK, 1'b0});
		for (int i = 0; i < 16; i++) begin
			shade = (i % 2) == 1;
			word = 16'($random(seed));
			index = IndexWidth'($random(seed));
			writeLatch({videoTimingPkg::LATCH_SEL_SHADOW, shade});
			// Unused select written with the opposite value
			writeLatch({videoTimingPkg::latchSelT'(1 + i % 6), ~shade});
			writePalette(index, word);
			checkPixel(index, refChannel(word, 0, shade), refChannel(word, 1, shade),
				refChannel(word, 2, shade));
		end

		$display("Value errors %0d, timeouts %0d, other errors %0d",
			valueErrors, timeoutErrors, otherErrors);
		if (valueErrors + timeoutErrors + otherErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/paletteTrace.txt ====
# op addr data red green blue, all hex
# W palette write, L latch write with addr, P pixel at index addr and expected colour
W 001 0FFF 00 00 00
W 002 7FFF 00 00 00
W 003 FFFF 00 00 00
W 004 8000 00 00 00
W 005 8421 00 00 00
W 006 8100 00 00 00
W 007 0A5C 00 00 00
W 008 2050 00 00 00
P 001 0000 F7 F7 F7
P 002 0000 FF FF FF
P 003 0000 FB FB FB
P 004 0000 00 00 00
P 005 0000 3D 1C 0C
P 006 0000 0C 00 00
P 007 0000 A5 52 C6
P 008 0000 00 5A 00
# shadow on, select 0 value 1
L 1 0000 00 00 00
P 007 0000 52 29 63
P 003 0000 7D 7D 7D
# selects 1 to 6 with value 1 change nothing
L 3 0000 00 00 00
L 5 0000 00 00 00
L 7 0000 00 00 00
L 9 0000 00 00 00
L B 0000 00 00 00
L D 0000 00 00 00
P 007 0000 52 29 63
L 0 0000 00 00 00
P 007 0000 A5 52 C6
# bank 1 holds a different word at the same index
L F 0000 00 00 00
W 007 0123 00 00 00
P 007 0000 10 21 31
L E 0000 00 00 00
P 007 0000 A5 52 C6

// ==== flist.f ====
verilog/paletteFormatPkg.sv
verilog/videoTimingPkg.sv
verilog/cpuBusIf.sv
verilog/systemLatch.sv
verilog/paletteRam.sv
verilog/pixelPipeline.sv
verilog/paletteTop.sv
sim/paletteTb.sv

// ==== Makefile ====
# Verilator build and run of the palette path testbench

VERILATOR ?= verilator
TOP ?= paletteTb
LOG ?= sim.log
BUILD_DIR ?= obj_dir
FLIST ?= flist.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

PASS_MSG := ALL TESTS PASSED
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

# The log decides pass or fail
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
